// ==== rtl/loader_pkg.sv ====
//////////////////////////////////////////////////
// loader package
// bus widths, address windows, status register map
// and the packed records shared by the load path
//////////////////////////////////////////////////

`default_nettype none

package loader_pkg;

  // bus widths
  localparam int bridge_addr_width   = 32;
  localparam int bridge_data_width   = 32;
  localparam int load_offset_width   = 20;
  localparam int status_offset_width = 24;

  // address windows, matched on the top of the bridge address
  localparam logic [3:0] load_window_nibble = 4'h1;
  localparam logic [7:0] status_window_byte = 8'hf8;

  //////////////////////////////////////////////////
  // status register map, byte offsets in the window

  localparam logic [status_offset_width-1:0] reg_ctrl      = 24'h00;
  localparam logic [status_offset_width-1:0] reg_accepted  = 24'h04;
  localparam logic [status_offset_width-1:0] reg_dropped   = 24'h08;
  localparam logic [status_offset_width-1:0] reg_completed = 24'h0c;
  localparam logic [status_offset_width-1:0] reg_errors    = 24'h10;

  //////////////////////////////////////////////////
  // records

  // one cycle of bridge request, rd and wr are strobes
  typedef struct packed {
    logic [bridge_addr_width-1:0] addr;
    logic                         rd;
    logic                         wr;
    logic [bridge_data_width-1:0] wr_data;
  } bridge_req_t;

  // captured word, byte offset into the load window
  typedef struct packed {
    logic [load_offset_width-1:0] offset;
    logic [bridge_data_width-1:0] data;
  } load_word_t;

  // axi4-lite write channels, master side
  typedef struct packed {
    logic [bridge_addr_width-1:0]   awaddr;
    logic                           awvalid;
    logic [bridge_data_width-1:0]   wdata;
    logic [bridge_data_width/8-1:0] wstrb;
    logic                           wvalid;
    logic                           bready;
  } axil_wr_req_t;

  // axi4-lite write channels, slave side
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  // status event counter
  typedef logic [15:0] count_t;

endpackage

`default_nettype wire

// ==== rtl/bridge_load_capture.sv ====
//////////////////////////////////////////////////
// bridge load capture
// turns load window writes into load records and
// offers each one to the fifo for a single cycle
//////////////////////////////////////////////////

`default_nettype none

module bridge_load_capture #(
  parameter bit bridge_little_endian = 1'b1
) (
  input  wire                         clk_74a,
  input  wire                         rst,
  input  wire loader_pkg::bridge_req_t bridge_req,
  input  wire                         load_active,
  input  wire                         push_ready,
  output logic                        push_valid,
  output loader_pkg::load_word_t      push_item,
  output logic                        word_accepted,
  output logic                        word_dropped
);
  import loader_pkg::*;

  logic                         window_hit;
  logic [bridge_data_width-1:0] word_data;

  // top nibble selects the load window, ignored while loading is off
  assign window_hit = bridge_req.wr && load_active &&
                      (bridge_req.addr[bridge_addr_width-1 -: 4] == load_window_nibble);

  // byte order of the incoming word
  generate
    if (bridge_little_endian) begin : g_little
      assign word_data = bridge_req.wr_data;
    end else begin : g_big
      // big-endian bridge, swap bytes end for end
      assign word_data = {bridge_req.wr_data[7:0], bridge_req.wr_data[15:8],
                          bridge_req.wr_data[23:16], bridge_req.wr_data[31:24]};
    end
  endgenerate

  // one push per window write
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      push_valid <= 1'b0;
    end else begin
      push_valid <= window_hit;
    end
  end

  // record payload, offset is the low address bits
  always_ff @(posedge clk_74a) begin
    if (window_hit) begin
      push_item.offset <= bridge_req.addr[load_offset_width-1:0];
      push_item.data   <= word_data;
    end
  end

  // nothing is held back, a full fifo loses the word
  assign word_accepted = push_valid && push_ready;
  assign word_dropped  = push_valid && !push_ready;

  // bridge strobes are spaced apart, so records never arrive back to back
  a_push_single: assert property (@(posedge clk_74a) disable iff (rst)
    push_valid |=> !push_valid);

endmodule

`default_nettype wire

// ==== rtl/load_fifo.sv ====
//////////////////////////////////////////////////
// load fifo
// synchronous circular buffer, the stored item
// type is set by the instantiating level
//////////////////////////////////////////////////

`default_nettype none

module load_fifo #(
  parameter int  fifo_depth = 8,
  parameter type item_t     = logic [31:0]
) (
  input  wire        clk_74a,
  input  wire        rst,
  input  wire        push_valid,
  input  wire item_t push_item,
  output logic       push_ready,
  output logic       pop_valid,
  output item_t      pop_item,
  input  wire        pop_ready
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);
  localparam logic [ptr_w-1:0] last_ptr   = ptr_w'(fifo_depth - 1);
  localparam logic [cnt_w-1:0] full_count = cnt_w'(fifo_depth);

  item_t            mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push_fire;
  logic             pop_fire;

  // flags straight from the occupancy count
  assign push_ready = (count != full_count);
  assign pop_valid  = (count != '0);
  assign pop_item   = mem[rd_ptr];
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  // storage
  always_ff @(posedge clk_74a) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_item;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_74a) disable iff (rst)
    count <= full_count);

  // from empty the count can only step up, a wrap below zero lands far higher
  a_no_underflow: assert property (@(posedge clk_74a) disable iff (rst)
    (count == '0) |=> (count <= cnt_w'(1)));

endmodule

`default_nettype wire

// ==== rtl/axil_load_writer.sv ====
//////////////////////////////////////////////////
// axi4-lite load writer
// pops load records, one write transaction each,
// a single transaction in flight
//////////////////////////////////////////////////

`default_nettype none

module axil_load_writer (
  input  wire                           clk_74a,
  input  wire                           rst,
  input  wire                           pop_valid,
  input  wire loader_pkg::load_word_t   pop_item,
  output logic                          pop_ready,
  output loader_pkg::axil_wr_req_t      axil_req,
  input  wire loader_pkg::axil_wr_rsp_t axil_rsp,
  output logic                          write_done,
  output logic                          write_error
);
  import loader_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_addr_data,
    st_resp
  } state_t;

  state_t                       state;
  logic                         aw_done;
  logic                         w_done;
  logic [bridge_addr_width-1:0] awaddr_q;
  logic [bridge_data_width-1:0] wdata_q;
  logic                         aw_fire;
  logic                         w_fire;
  logic                         b_fire;
  logic                         take;

  assign aw_fire = axil_req.awvalid && axil_rsp.awready;
  assign w_fire  = axil_req.wvalid && axil_rsp.wready;
  assign b_fire  = (state == st_resp) && axil_rsp.bvalid;

  // next record may be taken in the response cycle
  assign pop_ready = (state == st_idle) || b_fire;
  assign take      = pop_valid && pop_ready;

  // channel valids come from state only
  always_comb begin
    axil_req.awaddr  = awaddr_q;
    axil_req.awvalid = (state == st_addr_data) && !aw_done;
    axil_req.wdata   = wdata_q;
    axil_req.wstrb   = '1;
    axil_req.wvalid  = (state == st_addr_data) && !w_done;
    axil_req.bready  = (state == st_resp);
  end

  assign write_done  = b_fire;
  assign write_error = b_fire && (axil_rsp.bresp != 2'b00);

  // payload, offset zero extended to a full address
  always_ff @(posedge clk_74a) begin
    if (take) begin
      awaddr_q <= bridge_addr_width'(pop_item.offset);
      wdata_q  <= pop_item.data;
    end
  end

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      state   <= st_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_addr_data;
          end
        end
        st_addr_data: begin
          // address and data may be accepted in either order
          if (aw_fire) begin
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            w_done <= 1'b1;
          end
          if ((aw_done || aw_fire) && (w_done || w_fire)) begin
            state   <= st_resp;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        st_resp: begin
          if (b_fire) begin
            state <= take ? st_addr_data : st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address payload holds while the slave stalls
  a_awaddr_stable: assert property (@(posedge clk_74a) disable iff (rst)
    axil_req.awvalid && !axil_rsp.awready |=> axil_req.awvalid && $stable(axil_req.awaddr));

endmodule

`default_nettype wire

// ==== rtl/bridge_status_regs.sv ====
//////////////////////////////////////////////////
// bridge status registers
// load enable, event counters and the registered
// bridge read mux for the command window
//////////////////////////////////////////////////

`default_nettype none

module bridge_status_regs (
  input  wire                                      clk_74a,
  input  wire                                      rst,
  input  wire loader_pkg::bridge_req_t             bridge_req,
  output logic [loader_pkg::bridge_data_width-1:0] bridge_rd_data,
  output logic                                     load_active,
  input  wire                                      word_accepted,
  input  wire                                      word_dropped,
  input  wire                                      write_done,
  input  wire                                      write_error
);
  import loader_pkg::*;

  // counter slots
  localparam int idx_accepted  = 0;
  localparam int idx_dropped   = 1;
  localparam int idx_completed = 2;
  localparam int idx_errors    = 3;

  logic                           status_hit;
  logic [status_offset_width-1:0] reg_offset;
  logic                           ctrl_wr;
  logic                           clear_counts;
  logic [3:0]                     events;
  count_t                         counts [4];
  logic [bridge_data_width-1:0]   rd_mux;

  assign status_hit = (bridge_req.addr[bridge_addr_width-1 -: 8] == status_window_byte);
  assign reg_offset = bridge_req.addr[status_offset_width-1:0];
  assign ctrl_wr    = bridge_req.wr && status_hit && (reg_offset == reg_ctrl);

  // only the off to on edge restarts the counts
  assign clear_counts = ctrl_wr && bridge_req.wr_data[0] && !load_active;
  assign events       = {write_error, write_done, word_dropped, word_accepted};

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      load_active <= 1'b0;
    end else if (ctrl_wr) begin
      load_active <= bridge_req.wr_data[0];
    end
  end

  always_ff @(posedge clk_74a) begin
    for (int i = 0; i < 4; i++) begin
      if (rst || clear_counts) begin
        counts[i] <= '0;
      end else if (events[i]) begin
        counts[i] <= counts[i] + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // read back, unmapped offsets read zero

  always_comb begin
    rd_mux = '0;
    if (status_hit) begin
      case (reg_offset)
        reg_ctrl:      rd_mux = bridge_data_width'(load_active);
        reg_accepted:  rd_mux = bridge_data_width'(counts[idx_accepted]);
        reg_dropped:   rd_mux = bridge_data_width'(counts[idx_dropped]);
        reg_completed: rd_mux = bridge_data_width'(counts[idx_completed]);
        reg_errors:    rd_mux = bridge_data_width'(counts[idx_errors]);
        default:       rd_mux = '0;
      endcase
    end
  end

  // value held until the next read strobe
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      bridge_rd_data <= '0;
    end else if (bridge_req.rd) begin
      bridge_rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/core_loader_top.sv ====
//////////////////////////////////////////////////
// core loader top
// bridge capture, load fifo and axi writer, with
// the status registers alongside
//////////////////////////////////////////////////

`default_nettype none

module core_loader_top #(
  parameter int fifo_depth           = 8,
  parameter bit bridge_little_endian = 1'b1
) (
  input  wire                                     clk_74a,
  input  wire                                     rst,
  input  wire loader_pkg::bridge_req_t            bridge_req,
  output wire [loader_pkg::bridge_data_width-1:0] bridge_rd_data,
  output wire loader_pkg::axil_wr_req_t           axil_req,
  input  wire loader_pkg::axil_wr_rsp_t           axil_rsp
);
  import loader_pkg::*;

  // capture to fifo
  logic       load_active;
  logic       push_valid;
  logic       push_ready;
  load_word_t push_item;
  // fifo to writer
  logic       pop_valid;
  logic       pop_ready;
  load_word_t pop_item;
  // events into the counters
  logic       word_accepted;
  logic       word_dropped;
  logic       write_done;
  logic       write_error;

  bridge_load_capture #(
    .bridge_little_endian(bridge_little_endian)
  ) bridge_load_capture_inst (
    .clk_74a      (clk_74a),
    .rst          (rst),
    .bridge_req   (bridge_req),
    .load_active  (load_active),
    .push_ready   (push_ready),
    .push_valid   (push_valid),
    .push_item    (push_item),
    .word_accepted(word_accepted),
    .word_dropped (word_dropped)
  );

  load_fifo #(
    .fifo_depth(fifo_depth),
    .item_t    (load_word_t)
  ) load_fifo_inst (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .push_valid(push_valid),
    .push_item (push_item),
    .push_ready(push_ready),
    .pop_valid (pop_valid),
    .pop_item  (pop_item),
    .pop_ready (pop_ready)
  );

  axil_load_writer axil_load_writer_inst (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .pop_valid  (pop_valid),
    .pop_item   (pop_item),
    .pop_ready  (pop_ready),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .write_done (write_done),
    .write_error(write_error)
  );

  bridge_status_regs bridge_status_regs_inst (
    .clk_74a       (clk_74a),
    .rst           (rst),
    .bridge_req    (bridge_req),
    .bridge_rd_data(bridge_rd_data),
    .load_active   (load_active),
    .word_accepted (word_accepted),
    .word_dropped  (word_dropped),
    .write_done    (write_done),
    .write_error   (write_error)
  );

endmodule

`default_nettype wire

// ==== tests/tb_core_loader.sv ====
//////////////////////////////////////////////////
// core loader testbench
// bridge stimulus, axi4-lite slave model and a
// scoreboard for the load path and status regs
//////////////////////////////////////////////////

`default_nettype none

module tb_core_loader;
  import loader_pkg::*;

  localparam int clk_period     = 100;
  localparam int drive_delay    = 10;
  localparam int fifo_depth     = 8;
  localparam bit little_endian  = 1'b0;
  // words sent over all tests, sets the watchdog budget
  localparam int total_words    = 84;
  localparam int timeout_cycles = total_words * 40 + 1000;

  logic                         clk_74a;
  logic                         rst;
  bridge_req_t                  bridge_req;
  logic [bridge_data_width-1:0] bridge_rd_data;
  axil_wr_req_t                 axil_req;
  axil_wr_rsp_t                 axil_rsp;

  // scoreboard queues, expected and seen on the axi side
  load_word_t  exp_q[$];
  load_word_t  got_q[$];
  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] lfsr_state;

  // slave model knobs
  int stall_len;
  bit err_mode;

  core_loader_top #(
    .fifo_depth          (fifo_depth),
    .bridge_little_endian(little_endian)
  ) core_loader_top_inst (
    .clk_74a       (clk_74a),
    .rst           (rst),
    .bridge_req    (bridge_req),
    .bridge_rd_data(bridge_rd_data),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp)
  );

  initial begin
    clk_74a = 1'b0;
    forever begin
      #(clk_period / 2) clk_74a = ~clk_74a;
    end
  end

  //////////////////////////////////////////////////
  // reference and random source

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  // offset is the low address bits, big-endian bridge reverses the bytes
  function automatic load_word_t expected_load_word(input logic [31:0] addr,
                                                    input logic [31:0] data);
    load_word_t w;
    w.offset = addr[load_offset_width-1:0];
    if (little_endian) begin
      w.data = data;
    end else begin
      w.data = {data[7:0], data[15:8], data[23:16], data[31:24]};
    end
    return w;
  endfunction

  task automatic check_load_word(input string name, input load_word_t got,
                                 input load_word_t want);
    if (got !== want) begin
      value_errors++;
      $display("ERROR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t want);
    if (got !== want) begin
      value_errors++;
      $display("ERROR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_rd_data(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      value_errors++;
      $display("ERROR %s got %h expected %h", name, got, want);
    end
  endtask

  //////////////////////////////////////////////////
  // bridge side

  // every drive lands a fixed delay after the rising edge
  task automatic idle_cycle();
    @(posedge clk_74a);
    #drive_delay;
  endtask

  // one strobe cycle then one quiet cycle
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_req.addr    = addr;
    bridge_req.wr_data = data;
    bridge_req.wr      = 1'b1;
    idle_cycle();
    bridge_req.wr = 1'b0;
    idle_cycle();
  endtask

  // data is registered on the strobe edge
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    bridge_req.addr = addr;
    bridge_req.rd   = 1'b1;
    idle_cycle();
    bridge_req.rd = 1'b0;
    data = bridge_rd_data;
  endtask

  task automatic read_and_check_data(input string name, input logic [31:0] addr,
                                     input logic [31:0] want);
    logic [31:0] data;
    bridge_read(addr, data);
    check_rd_data(name, data, want);
  endtask

  task automatic read_and_check_count(input string name, input logic [23:0] offset,
                                      input count_t want, output count_t got);
    logic [31:0] data;
    bridge_read({status_window_byte, offset}, data);
    got = count_t'(data);
    check_count(name, got, want);
  endtask

  task automatic set_loading(input bit on);
    bridge_write({status_window_byte, reg_ctrl}, {31'h0, on});
  endtask

  // random word aligned window writes, the first keep of them are expected out
  task automatic send_random_words(input int n, input int gap, input int keep,
                                   output int bit2_count);
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    load_word_t  want;
    bit2_count = 0;
    for (int i = 0; i < n; i++) begin
      rnd  = draw_bits(26);
      addr = {load_window_nibble, rnd[25:18], rnd[17:0], 2'b00};
      data = draw_bits(32);
      want = expected_load_word(addr, data);
      if (i < keep) begin
        exp_q.push_back(want);
        if (want.offset[2]) begin
          bit2_count++;
        end
      end
      bridge_write(addr, data);
      repeat (gap) idle_cycle();
    end
  endtask

  // let the writer empty the fifo, then settle the counters
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      idle_cycle();
    end
    repeat (20) idle_cycle();
  endtask

  //////////////////////////////////////////////////
  // axi4-lite slave model

  initial begin : axil_slave
    bit           aw_hs;
    bit           w_hs;
    bit           b_hs;
    bit           busy;
    bit           have_aw;
    bit           have_w;
    int           wait_left;
    logic [31:0]  cap_addr;
    logic [31:0]  cap_data;
    load_word_t   resp_item;
    axil_wr_req_t s_req;
    busy      = 1'b0;
    have_aw   = 1'b0;
    have_w    = 1'b0;
    wait_left = 0;
    cap_addr  = '0;
    cap_data  = '0;
    resp_item = '0;
    axil_rsp  = '0;
    forever begin
      // handshakes settle by the falling edge and fire on the next rising one
      @(negedge clk_74a);
      s_req = axil_req;
      aw_hs = s_req.awvalid && axil_rsp.awready;
      w_hs  = s_req.wvalid && axil_rsp.wready;
      b_hs  = s_req.bready && axil_rsp.bvalid;
      idle_cycle();
      if (b_hs) begin
        got_q.push_back(resp_item);
        axil_rsp.bvalid = 1'b0;
        busy            = 1'b0;
      end
      if (aw_hs) begin
        have_aw  = 1'b1;
        cap_addr = s_req.awaddr;
      end
      if (w_hs) begin
        have_w   = 1'b1;
        cap_data = s_req.wdata;
        if (s_req.wstrb != 4'hf) begin
          other_errors++;
          $display("write strobe was not all ones on a load write");
        end
      end
      // both halves in, answer; bit 2 errors only when asked
      if (have_aw && have_w) begin
        if (cap_addr[31:load_offset_width] != '0) begin
          other_errors++;
          $display("write address %h has bits set above the load offset", cap_addr);
        end
        resp_item.offset = cap_addr[load_offset_width-1:0];
        resp_item.data   = cap_data;
        axil_rsp.bvalid  = 1'b1;
        axil_rsp.bresp   = (err_mode && cap_addr[2]) ? 2'b10 : 2'b00;
        have_aw          = 1'b0;
        have_w           = 1'b0;
      end
      // a fresh request loads its stall count
      if (!busy && s_req.awvalid) begin
        busy      = 1'b1;
        wait_left = stall_len;
      end else if (wait_left > 0) begin
        wait_left--;
      end
      axil_rsp.awready = busy && (wait_left == 0) && !have_aw && !axil_rsp.bvalid;
      axil_rsp.wready  = busy && (wait_left == 0) && !have_w && !axil_rsp.bvalid;
    end
  end

  // completed writes against the expected order
  initial begin : compare
    load_word_t got;
    load_word_t want;
    forever begin
      @(negedge clk_74a);
      while (got_q.size() != 0) begin
        got = got_q.pop_front();
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("unexpected axi write to offset %h with data %h", got.offset, got.data);
        end else begin
          want = exp_q.pop_front();
          check_load_word("axil_req awaddr and wdata", got, want);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk_74a);
    $display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence

  initial begin : stimulus
    int          scratch;
    int          err5;
    logic [31:0] rnd;
    count_t      acc;
    count_t      drop;
    count_t      seen;
    lfsr_state = 32'hed47;
    rst        = 1'b1;
    bridge_req = '0;
    stall_len  = 0;
    err_mode   = 1'b0;
    repeat (16) @(posedge clk_74a);
    #drive_delay;
    rst = 1'b0;
    idle_cycle();

    // 1 reset state, everything reads zero
    check_rd_data("bridge_rd_data", bridge_rd_data, 32'h0);
    read_and_check_data("reg_ctrl", {status_window_byte, reg_ctrl}, 32'h0);
    read_and_check_count("reg_accepted", reg_accepted, 16'd0, seen);
    read_and_check_count("reg_dropped", reg_dropped, 16'd0, seen);
    read_and_check_count("reg_completed", reg_completed, 16'd0, seen);
    read_and_check_count("reg_errors", reg_errors, 16'd0, seen);
    if (axil_req.awvalid !== 1'b0) begin
      other_errors++;
      $display("awvalid was raised with nothing loaded");
    end

    // 2 fast slave, words come out in order
    set_loading(1'b1);
    send_random_words(24, 2, 24, scratch);
    wait_drain();
    read_and_check_count("reg_accepted", reg_accepted, 16'd24, seen);
    read_and_check_count("reg_completed", reg_completed, 16'd24, seen);
    read_and_check_count("reg_dropped", reg_dropped, 16'd0, seen);
    read_and_check_count("reg_errors", reg_errors, 16'd0, seen);

    // 3 writes outside both windows, then window writes with loading off
    for (int i = 0; i < 8; i++) begin
      rnd = draw_bits(31);
      bridge_write({4'h2 + {1'b0, rnd[30:28]}, rnd[27:0]}, draw_bits(32));
    end
    set_loading(1'b0);
    send_random_words(8, 0, 0, scratch);
    wait_drain();
    read_and_check_data("reg_ctrl", {status_window_byte, reg_ctrl}, 32'h0);
    read_and_check_count("reg_accepted", reg_accepted, 16'd24, seen);
    read_and_check_count("reg_completed", reg_completed, 16'd24, seen);
    read_and_check_count("reg_dropped", reg_dropped, 16'd0, seen);

    // 4 stalled slave, writer holds one and the fifo the next depth
    set_loading(1'b1);
    stall_len = 60 + int'(draw_bits(4));
    send_random_words(20, 0, fifo_depth + 1, scratch);
    stall_len = 0;
    wait_drain();
    read_and_check_count("reg_accepted", reg_accepted, count_t'(fifo_depth + 1), acc);
    read_and_check_count("reg_dropped", reg_dropped, count_t'(19 - fifo_depth), drop);
    check_count("reg_accepted plus reg_dropped", acc + drop, 16'd20);
    read_and_check_count("reg_completed", reg_completed, count_t'(fifo_depth + 1), seen);

    // 5 slave errors on offset bit 2
    set_loading(1'b0);
    set_loading(1'b1);
    err_mode  = 1'b1;
    stall_len = int'(draw_bits(2));
    send_random_words(24, 6, 24, err5);
    wait_drain();
    err_mode  = 1'b0;
    stall_len = 0;
    read_and_check_count("reg_errors", reg_errors, count_t'(err5), seen);
    read_and_check_count("reg_completed", reg_completed, 16'd24, seen);
    read_and_check_count("reg_dropped", reg_dropped, 16'd0, seen);

    // 6 counters cleared on the off to on edge, unmapped reads are zero
    set_loading(1'b0);
    set_loading(1'b1);
    read_and_check_data("reg_ctrl", {status_window_byte, reg_ctrl}, 32'h1);
    read_and_check_count("reg_accepted", reg_accepted, 16'd0, seen);
    read_and_check_count("reg_dropped", reg_dropped, 16'd0, seen);
    read_and_check_count("reg_completed", reg_completed, 16'd0, seen);
    read_and_check_count("reg_errors", reg_errors, 16'd0, seen);
    read_and_check_data("bridge_rd_data at 14", {status_window_byte, 24'h14}, 32'h0);
    read_and_check_data("bridge_rd_data at 80", {status_window_byte, 24'h80}, 32'h0);
    read_and_check_data("bridge_rd_data at fffffc", {status_window_byte, 24'hfffffc}, 32'h0);
    read_and_check_data("bridge_rd_data in load window", 32'h1000_0000, 32'h0);

    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/loader_pkg.sv
rtl/bridge_load_capture.sv
rtl/load_fifo.sv
rtl/axil_load_writer.sv
rtl/bridge_status_regs.sv
rtl/core_loader_top.sv
tests/tb_core_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core loader testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_core_loader -f all.f
./obj_dir/Vtb_core_loader > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
